// File: source/bp_types_pkg.sv
// branch kind encoding, pc width, saturating counter type and its reset value
package bp_types_pkg;

    // word pc without the byte offset
    localparam int pc_width = 30;

    // resolved control-flow kind as reported by execute
    typedef enum logic [2:0] {
        NOT_JUMP = 3'd0,
        COND     = 3'd1,  // only kind that trains counters
        RET      = 3'd4,
        INDIRECT = 3'd5,
        CALL     = 3'd6,
        JUMP     = 3'd7
    } branch_kind_t;

    // 2-bit saturating counter whose msb is the prediction
    typedef logic [1:0] counter_t;

    // weakly not taken
    localparam counter_t counter_reset = 2'b01;

endpackage

// File: source/bp_config_pkg.sv
// default predictor sizes: bank count, table depth, update buffer depth, bank queue depth
package bp_config_pkg;

    // power-of-two count of banks interleaved by the low pc bits
    localparam int num_banks = 4;

    // saturating counters per bank
    localparam int bank_entries = 16;

    // update buffer slots for at least one dual push
    localparam int buf_depth = 8;

    // update queue slots per bank and the initial credit count
    localparam int bank_qdepth = 2;

endpackage

// File: source/bp_update_buffer.sv
// dual-lane in-order FIFO of COND outcomes, per-bank credits, return address register
`timescale 1ns/10ps

module bp_update_buffer #(
    parameter int num_banks    = bp_config_pkg::num_banks,
    parameter int bank_entries = bp_config_pkg::bank_entries,
    parameter int buf_depth    = bp_config_pkg::buf_depth,
    parameter int bank_qdepth  = bp_config_pkg::bank_qdepth
) (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              in_valid_0,
    input  logic [bp_types_pkg::pc_width-1:0] in_pc_0,
    input  logic                              in_taken_0,
    input  bp_types_pkg::branch_kind_t        in_kind_0,
    input  logic                              in_valid_1,
    input  logic [bp_types_pkg::pc_width-1:0] in_pc_1,
    input  logic                              in_taken_1,
    input  bp_types_pkg::branch_kind_t        in_kind_1,
    output logic                              in_ready,
    output logic                              ret_valid,
    output logic [bp_types_pkg::pc_width-1:0] ret_pc,
    output logic [num_banks-1:0]              upd_valid,
    output logic [$clog2(bank_entries)-1:0]   upd_index,
    output logic                              upd_taken,
    input  logic [num_banks-1:0]              credit_return
);
    import bp_types_pkg::*;

    localparam int bank_bits = $clog2(num_banks);
    localparam int idx_bits  = $clog2(bank_entries);
    localparam int ptr_w     = (buf_depth > 1) ? $clog2(buf_depth) : 1;
    localparam int cnt_w     = $clog2(buf_depth + 1);
    localparam int cred_w    = $clog2(bank_qdepth + 1);

    logic [bank_bits-1:0] fifo_bank  [buf_depth];
    logic [idx_bits-1:0]  fifo_index [buf_depth];
    logic                 fifo_taken [buf_depth];

    logic [ptr_w-1:0]     wr_ptr;
    logic [ptr_w-1:0]     wr_ptr_1;
    logic [ptr_w-1:0]     rd_ptr;
    logic [cnt_w-1:0]     count;
    logic [cred_w-1:0]    credit [num_banks];

    logic                 keep_0;
    logic                 keep_1;
    logic                 call_0;
    logic                 call_1;
    logic                 issue;
    logic [bank_bits-1:0] head_bank;

    // wraps at buf_depth, which need not be a power of two
    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] p);
        if (p == ptr_w'(buf_depth - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign in_ready = (count <= cnt_w'(buf_depth - 2));  // room for both lanes

    // non-COND reports are dropped here
    assign keep_0 = in_ready && in_valid_0 && (in_kind_0 == COND);
    assign keep_1 = in_ready && in_valid_1 && (in_kind_1 == COND);
    assign wr_ptr_1 = keep_0 ? ptr_inc(wr_ptr) : wr_ptr;

    // a head without credit blocks all later entries
    assign head_bank = fifo_bank[rd_ptr];
    assign issue     = (count != '0) && (credit[head_bank] != '0);
    assign upd_valid = issue ? (num_banks'(1) << head_bank) : '0;
    assign upd_index = fifo_index[rd_ptr];
    assign upd_taken = fifo_taken[rd_ptr];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (keep_1) begin
                wr_ptr <= ptr_inc(wr_ptr_1);
            end else if (keep_0) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (issue) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            count <= count + cnt_w'(keep_0) + cnt_w'(keep_1) - cnt_w'(issue);
        end
    end

    // lane 0 is older, so it lands first
    always_ff @(posedge clk) begin
        if (keep_0) begin
            fifo_bank[wr_ptr]  <= in_pc_0[bank_bits-1:0];
            fifo_index[wr_ptr] <= in_pc_0[bank_bits +: idx_bits];
            fifo_taken[wr_ptr] <= in_taken_0;
        end
        if (keep_1) begin
            fifo_bank[wr_ptr_1]  <= in_pc_1[bank_bits-1:0];
            fifo_index[wr_ptr_1] <= in_pc_1[bank_bits +: idx_bits];
            fifo_taken[wr_ptr_1] <= in_taken_1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int b = 0; b < num_banks; b++) begin
                credit[b] <= cred_w'(bank_qdepth);
            end
        end else begin
            for (int b = 0; b < num_banks; b++) begin
                credit[b] <= credit[b] + cred_w'(credit_return[b]) - cred_w'(upd_valid[b]);
            end
        end
    end

    assign call_0 = in_valid_0 && (in_kind_0 == CALL);
    assign call_1 = in_valid_1 && (in_kind_1 == CALL);

    always_ff @(posedge clk) begin
        if (!rstn) begin
            ret_valid <= 1'b0;
        end else begin
            ret_valid <= in_ready && (call_0 || call_1);
        end
    end

    // lane 0 call wins over lane 1
    always_ff @(posedge clk) begin
        if (in_ready && call_0) begin
            ret_pc <= in_pc_0 + pc_width'(1);
        end else if (in_ready && call_1) begin
            ret_pc <= in_pc_1 + pc_width'(1);
        end
    end

endmodule

// File: source/bp_counter_bank.sv
// saturating counter table, small update queue, lookup-priority read port
`timescale 1ns/10ps

module bp_counter_bank #(
    parameter int bank_entries = bp_config_pkg::bank_entries,
    parameter int bank_qdepth  = bp_config_pkg::bank_qdepth
) (
    input  logic                            clk,
    input  logic                            rstn,
    input  logic                            upd_valid,
    input  logic [$clog2(bank_entries)-1:0] upd_index,
    input  logic                            upd_taken,
    output logic                            credit_return,
    input  logic                            rd_valid,
    input  logic [$clog2(bank_entries)-1:0] rd_index,
    output bp_types_pkg::counter_t          rd_data
);
    import bp_types_pkg::*;

    localparam int idx_bits = $clog2(bank_entries);
    localparam int qp_w     = (bank_qdepth > 1) ? $clog2(bank_qdepth) : 1;
    localparam int qc_w     = $clog2(bank_qdepth + 1);

    counter_t            table_q [bank_entries];
    logic [idx_bits-1:0] q_index [bank_qdepth];
    logic                q_taken [bank_qdepth];
    logic [qp_w-1:0]     q_head;
    logic [qp_w-1:0]     q_tail;
    logic [qc_w-1:0]     q_count;
    logic                apply;
    counter_t            cur;
    counter_t            nxt;

    function automatic logic [qp_w-1:0] q_inc(input logic [qp_w-1:0] p);
        if (p == qp_w'(bank_qdepth - 1)) begin
            return '0;
        end
        return p + 1'b1;
    endfunction

    assign apply         = (q_count != '0) && !rd_valid;  // read owns the port
    assign credit_return = apply;

    // saturating step of the head entry
    assign cur = table_q[q_index[q_head]];
    always_comb begin
        nxt = cur;
        if (q_taken[q_head] && cur != 2'b11) begin
            nxt = cur + 2'b01;
        end else if (!q_taken[q_head] && cur != 2'b00) begin
            nxt = cur - 2'b01;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            q_head  <= '0;
            q_tail  <= '0;
            q_count <= '0;
            for (int i = 0; i < bank_entries; i++) begin
                table_q[i] <= counter_reset;
            end
        end else begin
            if (upd_valid) begin
                q_tail <= q_inc(q_tail);
            end
            if (apply) begin
                q_head <= q_inc(q_head);
                table_q[q_index[q_head]] <= nxt;
            end
            q_count <= q_count + qc_w'(upd_valid) - qc_w'(apply);
        end
    end

    // credits keep the queue from overflowing
    always_ff @(posedge clk) begin
        if (upd_valid) begin
            q_index[q_tail] <= upd_index;
            q_taken[q_tail] <= upd_taken;
        end
        if (rd_valid) begin
            rd_data <= table_q[rd_index];
        end
    end

endmodule

// File: source/bp_predict_mux.sv
// query decode to bank and index, registered bank select, prediction output
`timescale 1ns/10ps

module bp_predict_mux #(
    parameter int num_banks    = bp_config_pkg::num_banks,
    parameter int bank_entries = bp_config_pkg::bank_entries
) (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              query_valid,
    input  logic [bp_types_pkg::pc_width-1:0] query_pc,
    output logic [num_banks-1:0]              rd_valid,
    output logic [$clog2(bank_entries)-1:0]   rd_index,
    input  bp_types_pkg::counter_t            rd_data [num_banks],
    output logic                              pred_valid,
    output logic                              pred_taken
);
    import bp_types_pkg::*;

    localparam int bank_bits = $clog2(num_banks);
    localparam int idx_bits  = $clog2(bank_entries);

    logic [bank_bits-1:0] bank_sel;
    logic [bank_bits-1:0] sel_q;
    counter_t             sel_data;

    assign bank_sel = query_pc[bank_bits-1:0];
    assign rd_index = query_pc[bank_bits +: idx_bits];
    assign rd_valid = query_valid ? (num_banks'(1) << bank_sel) : '0;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            pred_valid <= 1'b0;
        end else begin
            pred_valid <= query_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (query_valid) begin
            sel_q <= bank_sel;  // bank answering next cycle
        end
    end

    assign sel_data   = rd_data[sel_q];
    assign pred_taken = sel_data[1];

endmodule

// File: source/bp_update_unit.sv
// update buffer, generate loop of counter banks, predict mux
`timescale 1ns/10ps

module bp_update_unit #(
    parameter int num_banks    = bp_config_pkg::num_banks,
    parameter int bank_entries = bp_config_pkg::bank_entries,
    parameter int buf_depth    = bp_config_pkg::buf_depth,
    parameter int bank_qdepth  = bp_config_pkg::bank_qdepth
) (
    input  logic                              clk,
    input  logic                              rstn,
    input  logic                              in_valid_0,
    input  logic [bp_types_pkg::pc_width-1:0] in_pc_0,
    input  logic                              in_taken_0,
    input  bp_types_pkg::branch_kind_t        in_kind_0,
    input  logic                              in_valid_1,
    input  logic [bp_types_pkg::pc_width-1:0] in_pc_1,
    input  logic                              in_taken_1,
    input  bp_types_pkg::branch_kind_t        in_kind_1,
    output logic                              in_ready,
    output logic                              ret_valid,
    output logic [bp_types_pkg::pc_width-1:0] ret_pc,
    input  logic                              query_valid,
    input  logic [bp_types_pkg::pc_width-1:0] query_pc,
    output logic                              pred_valid,
    output logic                              pred_taken
);
    import bp_types_pkg::*;

    localparam int idx_bits = $clog2(bank_entries);

    logic [num_banks-1:0] upd_valid;
    logic [idx_bits-1:0]  upd_index;
    logic                 upd_taken;
    logic [num_banks-1:0] credit_return;
    logic [num_banks-1:0] rd_valid;
    logic [idx_bits-1:0]  rd_index;
    counter_t             rd_data [num_banks];

    bp_update_buffer #(
        .num_banks    (num_banks),
        .bank_entries (bank_entries),
        .buf_depth    (buf_depth),
        .bank_qdepth  (bank_qdepth)
    ) buffer_i (
        .clk           (clk),
        .rstn          (rstn),
        .in_valid_0    (in_valid_0),
        .in_pc_0       (in_pc_0),
        .in_taken_0    (in_taken_0),
        .in_kind_0     (in_kind_0),
        .in_valid_1    (in_valid_1),
        .in_pc_1       (in_pc_1),
        .in_taken_1    (in_taken_1),
        .in_kind_1     (in_kind_1),
        .in_ready      (in_ready),
        .ret_valid     (ret_valid),
        .ret_pc        (ret_pc),
        .upd_valid     (upd_valid),
        .upd_index     (upd_index),
        .upd_taken     (upd_taken),
        .credit_return (credit_return)
    );

    // update and read buses are shared, only the valids are per bank
    for (genvar g = 0; g < num_banks; g++) begin : g_bank
        bp_counter_bank #(
            .bank_entries (bank_entries),
            .bank_qdepth  (bank_qdepth)
        ) bank_i (
            .clk           (clk),
            .rstn          (rstn),
            .upd_valid     (upd_valid[g]),
            .upd_index     (upd_index),
            .upd_taken     (upd_taken),
            .credit_return (credit_return[g]),
            .rd_valid      (rd_valid[g]),
            .rd_index      (rd_index),
            .rd_data       (rd_data[g])
        );
    end

    bp_predict_mux #(
        .num_banks    (num_banks),
        .bank_entries (bank_entries)
    ) mux_i (
        .clk         (clk),
        .rstn        (rstn),
        .query_valid (query_valid),
        .query_pc    (query_pc),
        .rd_valid    (rd_valid),
        .rd_index    (rd_index),
        .rd_data     (rd_data),
        .pred_valid  (pred_valid),
        .pred_taken  (pred_taken)
    );

endmodule

// File: verification/bp_update_unit_properties.sv
// concurrent assertions on prediction timing, bank credits and return-address reset
`timescale 1ns/10ps

module bp_update_unit_properties #(
    parameter int num_banks   = bp_config_pkg::num_banks,
    parameter int bank_qdepth = bp_config_pkg::bank_qdepth
) (
    input logic                               clk,
    input logic                               rstn,
    input logic                               query_valid,
    input logic                               pred_valid,
    input logic                               ret_valid,
    input logic [num_banks-1:0]               upd_valid,
    input logic [$clog2(bank_qdepth + 1)-1:0] credit [num_banks]
);
    int fails = 0;

    pred_timing: assert property (@(posedge clk) disable iff (!rstn)
        pred_valid == $past(query_valid))
        else begin
            fails++;
            $error("pred_valid does not follow query_valid by one cycle");
        end

    ret_in_reset: assert property (@(posedge clk) !rstn |=> !ret_valid)
        else begin
            fails++;
            $error("ret_valid high during reset");
        end

    for (genvar b = 0; b < num_banks; b++) begin : g_credit
        issue_needs_credit: assert property (@(posedge clk) disable iff (!rstn)
            upd_valid[b] |-> credit[b] != '0)
            else begin
                fails++;
                $error("bank %0d got an update with no credit left", b);
            end

        credit_bounded: assert property (@(posedge clk) disable iff (!rstn)
            credit[b] <= bank_qdepth)
            else begin
                fails++;
                $error("bank %0d credit count above queue depth", b);
            end
    end

endmodule

bind bp_update_unit bp_update_unit_properties #(
    .num_banks   (num_banks),
    .bank_qdepth (bank_qdepth)
) props_i (
    .clk         (clk),
    .rstn        (rstn),
    .query_valid (query_valid),
    .pred_valid  (pred_valid),
    .ret_valid   (ret_valid),
    .upd_valid   (upd_valid),
    .credit      (buffer_i.credit)
);

// File: verification/bp_update_unit_tb.sv
// testbench clock, reset, counter model, directed tests, checks and timeout
`timescale 1ns/10ps

module bp_update_unit_tb;
    import bp_types_pkg::*;
    import bp_config_pkg::*;

    localparam int drain_cycles = buf_depth + 4;
    localparam int max_cycles   = 4000;  // tests need well under 1000

    logic                clk;
    logic                rstn;
    logic                in_valid_0;
    logic [pc_width-1:0] in_pc_0;
    logic                in_taken_0;
    branch_kind_t        in_kind_0;
    logic                in_valid_1;
    logic [pc_width-1:0] in_pc_1;
    logic                in_taken_1;
    branch_kind_t        in_kind_1;
    logic                in_ready;
    logic                ret_valid;
    logic [pc_width-1:0] ret_pc;
    logic                query_valid;
    logic [pc_width-1:0] query_pc;
    logic                pred_valid;
    logic                pred_taken;

    counter_t model [num_banks][bank_entries];
    int       errors;
    int       seed;
    int       cycles;

    bp_update_unit #(
        .num_banks    (num_banks),
        .bank_entries (bank_entries),
        .buf_depth    (buf_depth),
        .bank_qdepth  (bank_qdepth)
    ) dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run did not finish within %0d cycles", max_cycles);
        $display("Done: errors found");
        $finish;
    end

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic drain();
        repeat (drain_cycles) step();
    endtask

    task automatic compare(input string name, input logic [31:0] actual,
                           input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("ERROR %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    // bank from the low pc bits and index from the bits above
    task automatic train(input logic [pc_width-1:0] pc, input logic taken);
        int       b;
        int       i;
        counter_t c;
        b = pc % num_banks;
        i = (pc / num_banks) % bank_entries;
        c = model[b][i];
        if (taken && c != 2'b11) begin
            c = c + 2'b01;
        end else if (!taken && c != 2'b00) begin
            c = c - 2'b01;
        end
        model[b][i] = c;
    endtask

    task automatic idle_lanes();
        in_valid_0 = 1'b0;
        in_pc_0    = '0;
        in_taken_0 = 1'b0;
        in_kind_0  = NOT_JUMP;
        in_valid_1 = 1'b0;
        in_pc_1    = '0;
        in_taken_1 = 1'b0;
        in_kind_1  = NOT_JUMP;
    endtask

    // the model learns only accepted reports in lane order
    task automatic drive_lanes(input logic v0, input logic [pc_width-1:0] pc0, input logic t0,
                               input branch_kind_t k0, input logic v1,
                               input logic [pc_width-1:0] pc1, input logic t1,
                               input branch_kind_t k1);
        in_valid_0 = v0;
        in_pc_0    = pc0;
        in_taken_0 = t0;
        in_kind_0  = k0;
        in_valid_1 = v1;
        in_pc_1    = pc1;
        in_taken_1 = t1;
        in_kind_1  = k1;
        if (in_ready && v0 && k0 == COND) train(pc0, t0);
        if (in_ready && v1 && k1 == COND) train(pc1, t1);
    endtask

    task automatic send_pair(input logic v0, input logic [pc_width-1:0] pc0, input logic t0,
                             input branch_kind_t k0, input logic v1,
                             input logic [pc_width-1:0] pc1, input logic t1,
                             input branch_kind_t k1);
        while (!in_ready) step();
        drive_lanes(v0, pc0, t0, k0, v1, pc1, t1, k1);
        step();
        idle_lanes();
    endtask

    task automatic query_and_compare(input logic [pc_width-1:0] pc);
        query_valid = 1'b1;
        query_pc    = pc;
        step();
        query_valid = 1'b0;
        compare("pred_valid", pred_valid, 1'b1);
        compare($sformatf("pred_taken[pc %h]", pc), pred_taken,
                model[pc % num_banks][(pc / num_banks) % bank_entries][1]);
    endtask

    task automatic sweep_counters();
        for (int b = 0; b < num_banks; b++) begin
            for (int i = 0; i < bank_entries; i++) begin
                query_and_compare(pc_width'(i * num_banks + b));
            end
        end
    endtask

    task automatic expect_return(input logic valid, input logic [pc_width-1:0] pc);
        compare("ret_valid", ret_valid, valid);
        if (valid) compare("ret_pc", ret_pc, pc);
    endtask

    task automatic reset_state();
        compare("in_ready", in_ready, 1'b1);
        compare("ret_valid", ret_valid, 1'b0);
        compare("pred_valid", pred_valid, 1'b0);
        repeat (4) begin
            query_and_compare($random(seed));
            compare("pred_taken", pred_taken, 1'b0);
        end
    endtask

    task automatic training();
        logic [pc_width-1:0] pc;
        pc = $random(seed);
        send_pair(1'b1, pc, 1'b1, COND, 1'b1, pc, 1'b1, COND);
        send_pair(1'b0, '0, 1'b0, NOT_JUMP, 1'b1, pc, 1'b1, COND);
        drain();
        query_and_compare(pc);
        compare("pred_taken", pred_taken, 1'b1);
        repeat (4) send_pair(1'b1, pc, 1'b0, COND, 1'b0, '0, 1'b0, NOT_JUMP);
        drain();
        query_and_compare(pc);
        compare("pred_taken", pred_taken, 1'b0);
    endtask

    task automatic interleave_and_filter();
        logic [pc_width-1:0] base;
        logic [pc_width-1:0] pc;
        base = $random(seed);
        for (int b = 0; b < num_banks; b++) begin
            pc = base + pc_width'(b);
            // second lane hits the same counter through aliasing
            send_pair(1'b1, pc, b[0], COND, 1'b1, pc + pc_width'(num_banks * bank_entries),
                      1'b1, COND);
        end
        // base and base + 2 sit at 01, where one stray taken update flips the prediction
        send_pair(1'b1, base, 1'b1, JUMP, 1'b1, base + 2, 1'b1, RET);
        send_pair(1'b1, base, 1'b1, INDIRECT, 1'b1, base + 2, 1'b1, JUMP);
        drain();
        sweep_counters();
    endtask

    task automatic return_address();
        logic [pc_width-1:0] p0;
        logic [pc_width-1:0] p1;
        p0 = $random(seed);
        p1 = $random(seed);
        send_pair(1'b1, p0, 1'b0, CALL, 1'b1, p1, 1'b0, NOT_JUMP);
        expect_return(1'b1, p0 + 1'b1);
        step();
        expect_return(1'b0, '0);
        send_pair(1'b1, p0, 1'b0, JUMP, 1'b1, p1, 1'b0, CALL);
        expect_return(1'b1, p1 + 1'b1);
        send_pair(1'b1, p0, 1'b0, CALL, 1'b1, p1, 1'b0, CALL);
        expect_return(1'b1, p0 + 1'b1);
        send_pair(1'b0, p0, 1'b0, CALL, 1'b1, p1, 1'b0, CALL);  // invalid lane 0 ignored
        expect_return(1'b1, p1 + 1'b1);
        send_pair(1'b1, p0, 1'b0, RET, 1'b1, p1, 1'b0, JUMP);
        expect_return(1'b0, '0);
    endtask

    task automatic back_pressure();
        logic [pc_width-1:0] pc;
        logic                low_seen;
        pc = $random(seed);
        low_seen = 1'b0;
        for (int n = 0; n < 24; n++) begin
            query_valid = 1'b1;
            query_pc    = pc;
            if (!in_ready) low_seen = 1'b1;
            drive_lanes(1'b1, pc + pc_width'(num_banks * n), $random(seed), COND,
                        1'b1, pc, $random(seed), COND);
            step();
        end
        idle_lanes();
        query_valid = 1'b0;
        compare("in_ready_low_seen", low_seen, 1'b1);
        drain();
        compare("in_ready", in_ready, 1'b1);
        sweep_counters();
    endtask

    task automatic random_mix();
        branch_kind_t        kinds [6];
        logic                v0;
        logic                v1;
        logic [pc_width-1:0] pc0;
        logic [pc_width-1:0] pc1;
        branch_kind_t        k0;
        branch_kind_t        k1;
        logic                exp_valid;
        logic [pc_width-1:0] exp_pc;
        kinds = '{NOT_JUMP, COND, RET, INDIRECT, CALL, JUMP};
        for (int n = 0; n < 200; n++) begin
            exp_valid = 1'b0;
            exp_pc    = '0;
            if (in_ready) begin
                v0  = $random(seed);
                v1  = $random(seed);
                pc0 = $random(seed) & 32'h7f;  // twice the table span so aliases occur
                pc1 = $random(seed) & 32'h7f;
                k0  = kinds[$unsigned($random(seed)) % 6];
                k1  = kinds[$unsigned($random(seed)) % 6];
                drive_lanes(v0, pc0, $random(seed), k0, v1, pc1, $random(seed), k1);
                exp_valid = (v0 && k0 == CALL) || (v1 && k1 == CALL);
                exp_pc    = (v0 && k0 == CALL) ? pc0 + 1'b1 : pc1 + 1'b1;
            end else begin
                idle_lanes();
            end
            step();
            expect_return(exp_valid, exp_pc);
        end
        idle_lanes();
        drain();
        sweep_counters();
    endtask

    initial begin
        seed   = 32'hbe73;
        errors = 0;
        rstn   = 1'b0;
        idle_lanes();
        query_valid = 1'b0;
        query_pc    = '0;
        for (int b = 0; b < num_banks; b++) begin
            for (int i = 0; i < bank_entries; i++) begin
                model[b][i] = 2'b01;  // weakly not taken
            end
        end
        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;

        reset_state();
        training();
        interleave_and_filter();
        return_address();
        back_pressure();
        random_mix();

        step();
        $display("errors: %0d check, %0d assertion", errors, dut_i.props_i.fails);
        if (errors + dut_i.props_i.fails == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: bp_update_unit.f
source/bp_types_pkg.sv
source/bp_config_pkg.sv
source/bp_update_buffer.sv
source/bp_counter_bank.sv
source/bp_predict_mux.sv
source/bp_update_unit.sv
verification/bp_update_unit_properties.sv
verification/bp_update_unit_tb.sv

// File: Bender.yml
package:
  name: bp_update_unit

sources:
  - source/bp_types_pkg.sv
  - source/bp_config_pkg.sv
  - source/bp_update_buffer.sv
  - source/bp_counter_bank.sv
  - source/bp_predict_mux.sv
  - source/bp_update_unit.sv
  - target: test
    files:
      - verification/bp_update_unit_properties.sv
      - verification/bp_update_unit_tb.sv
